//--- Bender.yml
package:
  name: mips_exec_core

sources:
  # Packages first, then the core from the leaves up
  - files:
      - verilog/mipsIsaPkg.sv
      - verilog/coreCtrlPkg.sv
      - verilog/registerFile.sv
      - verilog/instrDecoder.sv
      - verilog/aluUnit.sv
      - verilog/mipsExecCore.sv
  # Testbench and bound checker
  - target: test
    files:
      - tests/mipsExecCore_checker.sv
      - tests/mipsExecCore_tb.sv

//--- mipsExecCore.f
verilog/mipsIsaPkg.sv
verilog/coreCtrlPkg.sv
verilog/registerFile.sv
verilog/instrDecoder.sv
verilog/aluUnit.sv
verilog/mipsExecCore.sv
tests/mipsExecCore_checker.sv
tests/mipsExecCore_tb.sv

//--- tests/mipsExecCore_checker.sv
module mipsExecCore_checker
#(
    parameter int dataWidth = 32,
    parameter int regCount  = 32
)
(
    input logic                 clk,
    input logic                 reset,
    input logic                 i_instrValid,
    input logic                 i_illegalInstr,
    input logic [dataWidth-1:0] i_regs [regCount]  // Register array of the core
);

    logic [regCount*dataWidth-1:0] regsFlat;

    // Whole array as one vector for $past
    always_comb
    begin
        for (int i = 0; i < regCount; i++)
            regsFlat[i*dataWidth +: dataWidth] = i_regs[i];
    end

    assert property (@(posedge clk) disable iff (reset) !i_instrValid |-> !i_illegalInstr)
    else $error("illegal flag high without a valid instruction");

    assert property (@(posedge clk) disable iff (reset) i_regs[0] == '0)
    else $error("register 0 does not read zero");

    // Falling-edge write of a cycle shows up by its closing rising edge
    assert property (@(posedge clk) disable iff (reset)
                     !i_instrValid |-> regsFlat == $past(regsFlat))
    else $error("register changed while no instruction was valid");

endmodule

bind mipsExecCore mipsExecCore_checker #(.dataWidth(dataWidth), .regCount(regCount)) coreChecker
(
    .clk            (clk),
    .reset          (reset),
    .i_instrValid   (i_instrValid),
    .i_illegalInstr (o_illegalInstr),
    .i_regs         (regFile.regArray)
);

//--- tests/mipsExecCore_tb.sv
module mipsExecCore_tb;

    // Predicted outcome of one instruction
    typedef struct packed
    {
        logic        illegal;
        logic        regWrite;
        logic [4:0]  dest;
        logic [31:0] result;
    } expectT;

    // Reset, sweep, R-type, I-type, chain, illegal, random
    localparam int testCycles = 3 + 35 + 13 + 9 + 9 + 43 + 335;
    localparam int cycleLimit = 2 * testCycles + 50;

    logic        clk = 1'b0;
    logic        reset;
    logic        i_instrValid;
    logic [31:0] i_instr;
    logic [4:0]  i_debugAddr;
    logic [31:0] o_aluResult;
    logic        o_illegalInstr;
    logic [31:0] o_debugData;
    logic [31:0] model [32];              // Mirror of the register array
    logic [31:0] lfsrState  = 32'h6f1417c0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testErrors = 0;
    int          testNum    = 0;
    int          cycleCount = 0;
    mipsIsaPkg::opcodeT opList [4] = '{mipsIsaPkg::ADDI, mipsIsaPkg::SLTI,
                                       mipsIsaPkg::ANDI, mipsIsaPkg::ORI};
    mipsIsaPkg::functT functList [6] = '{mipsIsaPkg::ADD, mipsIsaPkg::SUB, mipsIsaPkg::AND,
                                         mipsIsaPkg::OR, mipsIsaPkg::NOR, mipsIsaPkg::SLT};

    mipsExecCore dut (.*);

    initial
    begin
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] randBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++)
        begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            value     = {value[30:0], lfsrState[0]}; // One step per bit
        end
        return value;
    endfunction

    function automatic logic [31:0] encodeR(input mipsIsaPkg::functT fn,
                                            input logic [4:0] rd, rs, rt);
        return {6'd0, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input mipsIsaPkg::opcodeT op,
                                            input logic [4:0] rt, rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic expectT refModel(input logic [31:0] instr, rsVal, rtVal);
        mipsIsaPkg::instrFieldsT f;
        expectT                  e;
        logic [31:0]             sImm;
        logic [31:0]             zImm;
        f    = instr;
        e    = '0;
        sImm = {{16{instr[15]}}, instr[15:0]}; // ADDI, SLTI
        zImm = {16'h0000, instr[15:0]};        // ANDI, ORI
        e.dest = (f.opcode == mipsIsaPkg::RTYPE) ? f.rd : f.rt;
        if (f.opcode == mipsIsaPkg::RTYPE)
        begin
            case (f.funct)
                mipsIsaPkg::ADD: e.result = rsVal + rtVal;
                mipsIsaPkg::SUB: e.result = rsVal - rtVal;
                mipsIsaPkg::AND: e.result = rsVal & rtVal;
                mipsIsaPkg::OR:  e.result = rsVal | rtVal;
                mipsIsaPkg::NOR: e.result = ~(rsVal | rtVal);
                mipsIsaPkg::SLT: e.result = 32'($signed(rsVal) < $signed(rtVal));
                default:         e.illegal = 1'b1;
            endcase
        end
        else
        begin
            case (f.opcode)
                mipsIsaPkg::ADDI: e.result = rsVal + sImm;
                mipsIsaPkg::SLTI: e.result = 32'($signed(rsVal) < $signed(sImm));
                mipsIsaPkg::ANDI: e.result = rsVal & zImm;
                mipsIsaPkg::ORI:  e.result = rsVal | zImm;
                default:          e.illegal = 1'b1;
            endcase
        end
        e.regWrite = !e.illegal && (e.dest != 5'd0); // r0 never written
        return e;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected, actual);
        checkCount++;
        assert (actual === expected)
        else
        begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparing process
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        expectT predicted;
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                model[i] = 32'(i); // Each register holds its index
        end
        else
        begin
            predicted = refModel(i_instr, model[i_instr[25:21]], model[i_instr[20:16]]);
            checkValue("o_illegalInstr", 32'(i_instrValid && predicted.illegal),
                       32'(o_illegalInstr));
            if (i_instrValid && !predicted.illegal)
                checkValue("o_aluResult", predicted.result, o_aluResult);
            if (i_instrValid && predicted.regWrite)
                model[predicted.dest] = predicted.result; // Same falling edge as DUT
        end
    end

    // Writeback visible on the debug port by the next rising edge
    always @(posedge clk)
    begin
        cycleCount++;
        if (!reset)
            checkValue("o_debugData", model[i_debugAddr], o_debugData);
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout after %0d cycles, tests did not finish", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic issue(input logic [31:0] instr, input logic valid);
        @(posedge clk);
        i_instr      <= instr;
        i_instrValid <= valid;
        i_debugAddr  <= (instr[31:26] == 6'd0) ? instr[15:11] : instr[20:16]; // Watch dest
    endtask

    task automatic sweep();
        for (int a = 0; a < 32; a++)
        begin
            @(posedge clk);
            i_instrValid <= 1'b0;
            i_debugAddr  <= 5'(a);
        end
    endtask

    task automatic finishTest(input string name);
        @(posedge clk);
        i_instrValid <= 1'b0;
        @(posedge clk); // Last debug check done
        $display("Test %0d %s: %0d errors", testNum, name, errorCount - testErrors);
        testNum++;
        testErrors = errorCount;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        reset        = 1'b1;
        i_instrValid = 1'b0;
        i_instr      = '0;
        i_debugAddr  = '0;
        testNum      = 1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        sweep();
        finishTest("reset sweep");
        issue(encodeI(mipsIsaPkg::ADDI, 10, 0, 16'hFFF9), 1'b1); // r10 = -7
        issue(encodeI(mipsIsaPkg::ADDI, 11, 0, 16'd100), 1'b1);
        issue(encodeR(mipsIsaPkg::ADD, 12, 10, 11), 1'b1);
        issue(encodeR(mipsIsaPkg::SUB, 13, 0, 11), 1'b1);        // Underflow
        issue(encodeR(mipsIsaPkg::SUB, 14, 10, 11), 1'b1);
        issue(encodeR(mipsIsaPkg::AND, 15, 10, 11), 1'b1);
        issue(encodeR(mipsIsaPkg::OR, 16, 10, 11), 1'b1);
        issue(encodeR(mipsIsaPkg::NOR, 17, 10, 11), 1'b1);
        issue(encodeR(mipsIsaPkg::SLT, 18, 10, 11), 1'b1);       // Negative vs positive
        issue(encodeR(mipsIsaPkg::SLT, 19, 11, 10), 1'b1);
        issue(encodeR(mipsIsaPkg::SLT, 20, 10, 10), 1'b1);
        finishTest("R-type");
        issue(encodeI(mipsIsaPkg::ADDI, 22, 11, 16'hFF38), 1'b1);
        issue(encodeI(mipsIsaPkg::ADDI, 23, 5, 16'h7FFF), 1'b1);
        issue(encodeI(mipsIsaPkg::SLTI, 24, 10, 16'hFFFD), 1'b1); // -7 < -3
        issue(encodeI(mipsIsaPkg::SLTI, 25, 11, 16'hFFFF), 1'b1);
        issue(encodeI(mipsIsaPkg::ANDI, 26, 10, 16'h8F0F), 1'b1); // No sign fill
        issue(encodeI(mipsIsaPkg::ORI, 27, 0, 16'hF000), 1'b1);
        issue(encodeI(mipsIsaPkg::ORI, 28, 10, 16'h8000), 1'b1);
        finishTest("I-type");
        issue(encodeI(mipsIsaPkg::ADDI, 1, 0, 16'd5), 1'b1);
        issue(encodeR(mipsIsaPkg::ADD, 2, 1, 1), 1'b1);
        issue(encodeR(mipsIsaPkg::SUB, 3, 2, 1), 1'b1);
        issue(encodeI(mipsIsaPkg::ADDI, 4, 3, 16'hFFFF), 1'b1);
        issue(encodeR(mipsIsaPkg::SLT, 5, 4, 3), 1'b1);
        issue(encodeI(mipsIsaPkg::ORI, 0, 4, 16'h00FF), 1'b1);  // Dropped
        issue(encodeR(mipsIsaPkg::ADD, 6, 0, 4), 1'b1);
        finishTest("dependent chain");
        issue({6'd2, 26'h0123456}, 1'b1);                    // Jump opcode
        issue({6'd35, 5'd1, 5'd7, 16'h0004}, 1'b1);          // Load opcode
        issue({6'd9, 5'd1, 5'd9, 16'h0010}, 1'b1);
        issue({6'd0, 5'd1, 5'd2, 5'd7, 5'd3, 6'd0}, 1'b1);   // Shift funct
        issue({6'd0, 5'd1, 5'd2, 5'd8, 5'd0, 6'd38}, 1'b1);  // XOR funct
        issue(encodeI(mipsIsaPkg::ADDI, 8, 0, 16'h1234), 1'b0); // Not valid
        sweep();
        finishTest("illegal and idle");
        for (int n = 0; n < 300; n++)
        begin
            if (randBits(1) == 32'd1)
                issue(encodeR(functList[randBits(3) % 6], 5'(randBits(5)), 5'(randBits(5)),
                              5'(randBits(5))), 1'b1);
            else
                issue(encodeI(opList[randBits(2)], 5'(randBits(5)), 5'(randBits(5)),
                              16'(randBits(16))), 1'b1);
        end
        sweep();
        finishTest("random");
        $display("Summary: %0d tests, %0d checks, %0d errors", testNum - 1, checkCount,
                 errorCount);
        if (errorCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- verilog/aluUnit.sv
module aluUnit
#(
    parameter int dataWidth = 32
)
(
    input  coreCtrlPkg::ctrlT     i_ctrl,
    input  logic [dataWidth-1:0]  i_rsData,  // Operand A
    input  logic [dataWidth-1:0]  i_rtData,
    input  logic [dataWidth-1:0]  i_imm,     // Already extended
    output logic [dataWidth-1:0]  o_result
);

    logic [dataWidth-1:0] opB;

    //////////////////////////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////////////////////////
    assign opB = i_ctrl.useImm ? i_imm : i_rtData; // I-type uses immediate

    //////////////////////////////////////////////////////////////////////
    // Operation
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        o_result = '0;
        case (i_ctrl.aluOp)
            coreCtrlPkg::ADD: o_result = i_rsData + opB; // Wraps, no overflow trap
            coreCtrlPkg::SUB: o_result = i_rsData - opB;
            coreCtrlPkg::AND: o_result = i_rsData & opB;
            coreCtrlPkg::OR:  o_result = i_rsData | opB;
            coreCtrlPkg::NOR: o_result = ~(i_rsData | opB);
            coreCtrlPkg::SLT:
            begin
                // Signed compare, 1 or 0 in bit 0
                o_result[0] = ($signed(i_rsData) < $signed(opB));
            end
            default: o_result = '0;
        endcase
    end

endmodule

//--- verilog/coreCtrlPkg.sv
// Control definitions shared by decoder, ALU and top level
package coreCtrlPkg;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0]
    {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        NOR = 3'd4,
        SLT = 3'd5  // Result is 1 or 0 in bit 0
    } aluOpT;

    // Control bundle from decoder to datapath
    typedef struct packed
    {
        logic       regWrite;   // Already qualified by valid, legal, dest != 0
        logic       useImm;     // Operand B from immediate
        logic       zeroExtend; // ANDI and ORI
        aluOpT      aluOp;
        logic [4:0] destReg;    // rd or rt
    } ctrlT;

endpackage

//--- verilog/instrDecoder.sv
module instrDecoder
#(
    parameter int dataWidth = 32  // At least 16
)
(
    input  logic                     i_instrValid,
    input  mipsIsaPkg::instrFieldsT  i_instr,
    output coreCtrlPkg::ctrlT        o_ctrl,
    output logic [4:0]               o_rsAddr,
    output logic [4:0]               o_rtAddr,
    output logic [dataWidth-1:0]     o_imm,
    output logic                     o_illegalInstr
);

    logic                                 legal;
    logic [mipsIsaPkg::immWidth-1:0]      immField;
    coreCtrlPkg::ctrlT                    ctrl;

    // Source registers straight from the fields
    assign o_rsAddr = i_instr.rs;
    assign o_rtAddr = i_instr.rt;
    assign immField = i_instr[mipsIsaPkg::immWidth-1:0]; // Low half of instruction

    //////////////////////////////////////////////////////////////////////
    // Opcode and funct decode
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        ctrl       = '0;
        ctrl.aluOp = coreCtrlPkg::ADD;
        legal      = 1'b1;
        case (mipsIsaPkg::opcodeT'(i_instr.opcode))
            mipsIsaPkg::RTYPE:
            begin
                ctrl.destReg = i_instr.rd; // R-type writes rd
                case (mipsIsaPkg::functT'(i_instr.funct))
                    mipsIsaPkg::ADD: ctrl.aluOp = coreCtrlPkg::ADD;
                    mipsIsaPkg::SUB: ctrl.aluOp = coreCtrlPkg::SUB;
                    mipsIsaPkg::AND: ctrl.aluOp = coreCtrlPkg::AND;
                    mipsIsaPkg::OR:  ctrl.aluOp = coreCtrlPkg::OR;
                    mipsIsaPkg::NOR: ctrl.aluOp = coreCtrlPkg::NOR;
                    mipsIsaPkg::SLT: ctrl.aluOp = coreCtrlPkg::SLT;
                    default:         legal = 1'b0; // Unknown funct
                endcase
            end
            mipsIsaPkg::ADDI:
            begin
                ctrl.useImm  = 1'b1;
                ctrl.destReg = i_instr.rt;
            end
            mipsIsaPkg::SLTI:
            begin
                ctrl.useImm  = 1'b1;
                ctrl.aluOp   = coreCtrlPkg::SLT;
                ctrl.destReg = i_instr.rt;
            end
            mipsIsaPkg::ANDI:
            begin
                ctrl.useImm     = 1'b1;
                ctrl.zeroExtend = 1'b1;
                ctrl.aluOp      = coreCtrlPkg::AND;
                ctrl.destReg    = i_instr.rt;
            end
            mipsIsaPkg::ORI:
            begin
                ctrl.useImm     = 1'b1;
                ctrl.zeroExtend = 1'b1;
                ctrl.aluOp      = coreCtrlPkg::OR;
                ctrl.destReg    = i_instr.rt;
            end
            default: legal = 1'b0; // Unknown opcode
        endcase

        // Writes to r0 dropped here, r0 stays zero
        ctrl.regWrite = i_instrValid && legal && (ctrl.destReg != 5'd0);
    end

    assign o_ctrl         = ctrl;
    assign o_illegalInstr = i_instrValid && !legal; // Only flagged for valid instr

    // Sign or zero extension of the 16-bit immediate
    assign o_imm = ctrl.zeroExtend ? dataWidth'(immField)
                                   : dataWidth'($signed(immField));

endmodule

//--- verilog/mipsExecCore.sv
module mipsExecCore
#(
    parameter int dataWidth = 32,  // At least 16
    parameter int regCount  = 32   // At most 32
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_instrValid,   // Level, one instr per cycle
    input  logic [31:0]           i_instr,
    input  logic [4:0]            i_debugAddr,
    output logic [dataWidth-1:0]  o_aluResult,
    output logic                  o_illegalInstr,
    output logic [dataWidth-1:0]  o_debugData
);

    coreCtrlPkg::ctrlT     ctrl;
    logic [4:0]            rsAddr;
    logic [4:0]            rtAddr;
    logic [dataWidth-1:0]  imm;
    logic [dataWidth-1:0]  rsData;
    logic [dataWidth-1:0]  rtData;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////
    instrDecoder #(.dataWidth(dataWidth)) decoder
    (
        .i_instrValid   (i_instrValid),
        .i_instr        (mipsIsaPkg::instrFieldsT'(i_instr)), // Field overlay
        .o_ctrl         (ctrl),
        .o_rsAddr       (rsAddr),
        .o_rtAddr       (rtAddr),
        .o_imm          (imm),
        .o_illegalInstr (o_illegalInstr)
    );

    // Register file, written back on the falling edge of this cycle
    registerFile #(.dataWidth(dataWidth), .regCount(regCount)) regFile
    (
        .clk         (clk),
        .reset       (reset),
        .i_regWrite  (ctrl.regWrite),
        .i_rsAddr    (rsAddr),
        .i_rtAddr    (rtAddr),
        .i_rdAddr    (ctrl.destReg),  // rd or rt, chosen in decoder
        .i_debugAddr (i_debugAddr),
        .i_writeData (o_aluResult),   // ALU result straight back
        .o_rsData    (rsData),
        .o_rtData    (rtData),
        .o_debugData (o_debugData)
    );

    // Execute
    aluUnit #(.dataWidth(dataWidth)) alu
    (
        .i_ctrl   (ctrl),
        .i_rsData (rsData),
        .i_rtData (rtData),
        .i_imm    (imm),
        .o_result (o_aluResult)
    );

endmodule

//--- verilog/mipsIsaPkg.sv
// Instruction-set definitions for the supported MIPS subset
package mipsIsaPkg;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes, bits 31:26
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0]
    {
        RTYPE = 6'd0,  // Operation chosen by funct
        ADDI  = 6'd8,
        SLTI  = 6'd10,
        ANDI  = 6'd12, // Zero-extended immediate
        ORI   = 6'd13  // Zero-extended immediate
    } opcodeT;

    //////////////////////////////////////////////////////////////////////
    // R-type funct codes, bits 5:0
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0]
    {
        ADD = 6'd32,
        SUB = 6'd34,
        AND = 6'd36,
        OR  = 6'd37,
        NOR = 6'd39,
        SLT = 6'd42    // Signed compare
    } functT;

    // Field overlay of one 32-bit instruction
    // Low 16 bits {rd, shamt, funct} double as the I-type immediate
    typedef struct packed
    {
        logic [5:0] opcode; // 31:26
        logic [4:0] rs;     // 25:21, first source
        logic [4:0] rt;     // 20:16, second source or I-type dest
        logic [4:0] rd;     // 15:11, R-type dest
        logic [4:0] shamt;  // 10:6, not used by this subset
        logic [5:0] funct;  // 5:0
    } instrFieldsT;

    // Immediate width inside the instruction
    localparam int immWidth = 16;

endpackage

//--- verilog/registerFile.sv
module registerFile
#(
    parameter int dataWidth = 32,
    parameter int regCount  = 32  // At most 32
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_regWrite,
    input  logic [4:0]           i_rsAddr,    // Read port 1
    input  logic [4:0]           i_rtAddr,    // Read port 2
    input  logic [4:0]           i_rdAddr,    // Write address
    input  logic [4:0]           i_debugAddr, // Debug read port
    input  logic [dataWidth-1:0] i_writeData,
    output logic [dataWidth-1:0] o_rsData,
    output logic [dataWidth-1:0] o_rtData,
    output logic [dataWidth-1:0] o_debugData
);

    logic [dataWidth-1:0] regArray [regCount];

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////
    // Combinational, no bypass needed since writes land mid-cycle
    // Addresses past regCount read as zero
    always_comb
    begin
        o_rsData    = '0;
        o_rtData    = '0;
        o_debugData = '0;
        if (i_rsAddr < regCount)
        begin
            o_rsData = regArray[i_rsAddr];
        end
        if (i_rtAddr < regCount)
        begin
            o_rtData = regArray[i_rtAddr];
        end
        if (i_debugAddr < regCount)
        begin
            o_debugData = regArray[i_debugAddr]; // Any register, any time
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write port on falling edge
    //////////////////////////////////////////////////////////////////////
    always_ff @(negedge clk)
    begin
        if (reset)
        begin
            // Each register starts at its own index, so r0 holds zero
            for (int i = 0; i < regCount; i++)
            begin
                regArray[i] <= dataWidth'(i);
            end
        end
        else if (i_regWrite && (i_rdAddr < regCount))
        begin
            regArray[i_rdAddr] <= i_writeData; // r0 filtered in decoder
        end
    end

endmodule
